/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* source/bus_pkg.sv */
`default_nettype none

`include "sys_cfg.svh"

// Processor side of the frame RAM
package bus_pkg;

  // One port A request per clock, no handshake
  // Write happens on every clock with we high
  // Reads are continuous, data one clock later
  typedef struct packed {
    logic                   we;   // Write strobe
    logic [`RAM_ADDR_W-1:0] addr; // Word address
    logic [31:0]            data; // Write data
  } mem_req_t;

endpackage

`default_nettype wire

/* source/frame_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sys_cfg.svh"

// One word per tile
// Port A belongs to the processor, port B to the scanner
module frame_ram (
  input  logic                   clk,
  input  bus_pkg::mem_req_t      a_req,  // Read/write port
  output logic [31:0]            a_data, // Registered, one clock late
  input  logic [`RAM_ADDR_W-1:0] b_addr, // Read only port
  output logic [31:0]            b_data  // Registered, one clock late
);

  localparam int DEPTH = 1 << `RAM_ADDR_W;

  logic [31:0] mem [0:DEPTH-1];

  // Port A
  // Old word comes out when the same address is written,
  // since the read samples the array before the update lands
  always_ff @(posedge clk) begin
    if (a_req.we) begin
      mem[a_req.addr] <= a_req.data;
    end
    a_data <= mem[a_req.addr];
  end

  // Port B
  // Scanner never writes, so just a registered read
  always_ff @(posedge clk) begin
    b_data <= mem[b_addr];
  end

endmodule

`default_nettype wire

/* source/run_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sys_cfg.svh"

// Keeps the processor parked until the button goes low,
// then seeds one RAM word and lets the processor run
module run_control (
  input  logic              clk,
  input  logic              reset,
  input  logic              btn,       // Active low
  input  bus_pkg::mem_req_t cpu_req,
  output logic              cpu_reset, // High while idle
  output bus_pkg::mem_req_t ram_req    // To frame RAM port A
);

  typedef enum logic {IDLE, RUNNING} state_t;

  state_t state, state_next;
  logic   start;      // Button seen while idle
  logic   init_pulse; // One clock after entering running

  assign start = (state == IDLE) && !btn;

  always_comb begin
    state_next = state; // Hold by default
    case (state)
      IDLE:    if (start) state_next = RUNNING;
      RUNNING: state_next = RUNNING; // No way back short of reset
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= IDLE;
      cpu_reset  <= 1'b1;
      init_pulse <= 1'b0;
    end else begin
      state      <= state_next;
      cpu_reset  <= (state_next == IDLE); // Drops on the start edge
      init_pulse <= start;                // Exactly one clock wide
    end
  end

  // Port A source select
  always_comb begin
    if (init_pulse) begin
      // Seed write wins over the processor for this cycle
      ram_req.we   = 1'b1;
      ram_req.addr = `RAM_ADDR_W'(`INIT_ADDR);
      ram_req.data = 32'(`INIT_DATA);
    end else if (state == RUNNING) begin
      ram_req = cpu_req; // Straight through
    end else begin
      ram_req = '0; // Idle, processor masked
    end
  end

endmodule

`default_nettype wire

/* source/sys_cfg.svh */
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

// Frame RAM geometry
`define RAM_ADDR_W 9 // Word address, 512 words, one per tile

// Horizontal timing in pixels, 800 per line
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96 // Active low pulse
`define H_BACK 48

// Vertical timing in lines, 525 per frame
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2 // Active low pulse
`define V_BACK 33

// Tile grid, 32 x 16 tiles cover the active area
`define TILE_W 20 // Pixels per tile
`define TILE_H 30 // Lines per tile
`define TILE_COLS 32 // Tiles per row, address low bits

// Write issued once when the processor is released
`define INIT_ADDR 1
`define INIT_DATA 1

`endif

/* source/vga_scan.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sys_cfg.svh"

// 640x480 scanner, one pixel per two clocks
// Tile counters run beside the raster counters so the
// RAM address is just {row, col}
module vga_scan (
  input  logic                    clk,
  input  logic                    reset,
  output logic [`RAM_ADDR_W-1:0]  vga_addr, // Tile word address
  input  logic [31:0]             vga_data, // Word for vga_addr, one clock late
  output video_pkg::video_out_t   video
);

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int H_W = $clog2(H_TOTAL);
  localparam int V_W = $clog2(V_TOTAL);
  localparam int COL_W = $clog2(`TILE_COLS);
  localparam int ROW_W = `RAM_ADDR_W - COL_W; // Remaining address bits
  localparam int SX_W = $clog2(`TILE_W);
  localparam int SY_W = $clog2(`TILE_H);

  localparam logic [H_W-1:0] H_LAST = H_W'(H_TOTAL - 1);
  localparam logic [H_W-1:0] H_ACT = H_W'(`H_ACTIVE);
  localparam logic [H_W-1:0] HS_START = H_W'(`H_ACTIVE + `H_FRONT);
  localparam logic [H_W-1:0] HS_END = H_W'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam logic [V_W-1:0] V_LAST = V_W'(V_TOTAL - 1);
  localparam logic [V_W-1:0] V_ACT = V_W'(`V_ACTIVE);
  localparam logic [V_W-1:0] VS_START = V_W'(`V_ACTIVE + `V_FRONT);
  localparam logic [V_W-1:0] VS_END = V_W'(`V_ACTIVE + `V_FRONT + `V_SYNC);
  localparam logic [SX_W-1:0] SX_LAST = SX_W'(`TILE_W - 1);
  localparam logic [SY_W-1:0] SY_LAST = SY_W'(`TILE_H - 1);

  logic             pix_en;   // High on every second clock
  logic [H_W-1:0]   h_cnt;    // Pixel in line
  logic [V_W-1:0]   v_cnt;    // Line in frame
  logic [SX_W-1:0]  sub_x;    // Pixel within tile
  logic [SY_W-1:0]  sub_y;    // Line within tile
  logic [COL_W-1:0] tile_col;
  logic [ROW_W-1:0] tile_row;
  logic             line_end; // Last pixel of a line, on pix_en
  logic             h_active;
  logic             v_active;
  logic             hsync_now;  // Raw syncs, active low
  logic             vsync_now;
  logic             s1_hsync;   // One clock behind, matches RAM latency
  logic             s1_vsync;
  logic             s1_active;

  assign line_end = pix_en && (h_cnt == H_LAST);
  assign h_active = h_cnt < H_ACT;
  assign v_active = v_cnt < V_ACT;
  assign hsync_now = !((h_cnt >= HS_START) && (h_cnt < HS_END));
  assign vsync_now = !((v_cnt >= VS_START) && (v_cnt < VS_END));
  assign vga_addr = {tile_row, tile_col};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) pix_en <= 1'b0;
    else       pix_en <= !pix_en; // Half rate
  end

  // Raster counters
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (pix_en) begin
      if (h_cnt == H_LAST) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1; // Frame wrap
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Tile column, steps every TILE_W pixels in the active part
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sub_x    <= '0;
      tile_col <= '0;
    end else if (line_end) begin
      sub_x    <= '0;
      tile_col <= '0;
    end else if (pix_en && h_active) begin
      if (sub_x == SX_LAST) begin
        sub_x    <= '0;
        tile_col <= tile_col + 1'b1; // Wraps to 0 after the last column
      end else begin
        sub_x <= sub_x + 1'b1;
      end
    end
  end

  // Tile row, steps every TILE_H lines
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sub_y    <= '0;
      tile_row <= '0;
    end else if (line_end) begin
      if (v_cnt == V_LAST) begin
        sub_y    <= '0;
        tile_row <= '0;
      end else if (v_active) begin
        if (sub_y == SY_LAST) begin
          sub_y    <= '0;
          tile_row <= tile_row + 1'b1;
        end else begin
          sub_y <= sub_y + 1'b1;
        end
      end
    end
  end

  // Delay stage, every clock, lines up with the RAM read
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_hsync  <= 1'b1;
      s1_vsync  <= 1'b1;
      s1_active <= 1'b0;
    end else begin
      s1_hsync  <= hsync_now;
      s1_vsync  <= vsync_now;
      s1_active <= h_active && v_active;
    end
  end

  // Output register, all video signals change together
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      video.hsync   <= 1'b1;
      video.vsync   <= 1'b1;
      video.sync_b  <= 1'b1;
      video.blank_b <= 1'b0;
      video.color   <= '0;
    end else begin
      video.hsync   <= s1_hsync;
      video.vsync   <= s1_vsync;
      video.sync_b  <= s1_hsync & s1_vsync;
      video.blank_b <= s1_active;
      video.color   <= s1_active ? video_pkg::rgb_t'(vga_data[23:0]) : '0; // Top byte unused
    end
  end

endmodule

`default_nettype wire

/* source/vga_system.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sys_cfg.svh"

// Top level: run control, shared frame RAM, VGA scanner
// Processor bus comes in from outside
module vga_system (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  btn,           // Active low start
  input  bus_pkg::mem_req_t     cpu_req,
  output logic [31:0]           cpu_read_data, // One clock after the address
  output logic                  cpu_reset,
  output video_pkg::video_out_t video
);

  bus_pkg::mem_req_t      ram_req;  // Port A after source select
  logic [`RAM_ADDR_W-1:0] vga_addr; // Port B address
  logic [31:0]            vga_data; // Port B data

  run_control u_run_control (
    .clk       (clk),
    .reset     (reset),
    .btn       (btn),
    .cpu_req   (cpu_req),
    .cpu_reset (cpu_reset),
    .ram_req   (ram_req)
  );

  frame_ram u_frame_ram (
    .clk    (clk),
    .a_req  (ram_req),
    .a_data (cpu_read_data),
    .b_addr (vga_addr),
    .b_data (vga_data)
  );

  vga_scan u_vga_scan (
    .clk      (clk),
    .reset    (reset),
    .vga_addr (vga_addr),
    .vga_data (vga_data),
    .video    (video)
  );

endmodule

`default_nettype wire

/* source/video_pkg.sv */
`default_nettype none

// Types on the display side
package video_pkg;

  // 24 bit color, r in the top byte as in the RAM word
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // Everything the monitor and DAC see, sampled together
  // Syncs are active low
  typedef struct packed {
    logic hsync;   // Horizontal sync
    logic vsync;   // Vertical sync
    logic sync_b;  // Composite sync, hsync & vsync
    logic blank_b; // Low outside the active area
    rgb_t color;   // Black while blanked
  } video_out_t;

endpackage

`default_nettype wire

/* tb.f */
+incdir+source
source/bus_pkg.sv
source/video_pkg.sv
source/run_control.sv
source/frame_ram.sv
source/vga_scan.sv
source/vga_system.sv
test/vga_system_sva.sv
test/tb_checker.sv
test/tb_top.sv

/* test/tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sys_cfg.svh"

// Samples the DUT ports on the falling edge
// Own RAM and controller model
// Raster position locks at the first falling vsync
module tb_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  btn,
  input  bus_pkg::mem_req_t     cpu_req,
  input  logic [31:0]           cpu_read_data,
  input  logic                  cpu_reset,
  input  video_pkg::video_out_t video,
  output int                    ctrl_errors,
  output int                    read_errors,
  output int                    sync_errors,
  output int                    color_errors
);

  localparam int WORDS = 1 << `RAM_ADDR_W;
  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int HS_FIRST = `H_ACTIVE + `H_FRONT; // First pixel of hsync
  localparam int VS_FIRST = `V_ACTIVE + `V_FRONT; // First line of vsync
  localparam longint LOCK_LIMIT = longint'(2 * H_TOTAL * V_TOTAL); // One frame of clocks
  localparam int SHOW_LIMIT = 40;

  // Port A read waiting one clock for its data
  typedef struct packed {
    logic        known;     // Model holds a real value
    logic        idle_hit;  // Target of a write tried while idle
    logic [31:0] data;
    logic [31:0] idle_data;
  } pend_t;

  logic [31:0] model [WORDS];
  logic [31:0] idle_data [WORDS];
  bit          known [WORDS];
  bit          idle_hit [WORDS];
  longint      last_wr [WORDS]; // Cycle of the latest write to each word
  longint      cyc;
  pend_t       pend;
  bit          running;         // Expected controller state
  bit          init_now;        // Seed write cycle
  bit          locked;          // Raster position known
  logic        prev_vsync;
  int          hc;              // Clock within line, two per pixel
  int          vc;              // Line within frame
  int          shown;

  initial begin
    ctrl_errors  = 0;
    read_errors  = 0;
    sync_errors  = 0;
    color_errors = 0;
    shown        = 0;
  end

  task automatic report(input string line);
    if (shown < SHOW_LIMIT) $display("%s", line);
    else if (shown == SHOW_LIMIT) $display("Too many errors, further ones only counted");
    shown++;
  endtask

  task automatic check_bus();
    logic        we;
    int          addr;
    logic [31:0] data;
    if (cpu_reset !== !running) begin
      ctrl_errors++;
      report($sformatf("[ERROR] cpu_reset: expected 0x%0h got 0x%0h", !running, cpu_reset));
    end
    if (init_now) begin // Seed write beats the processor
      we   = 1'b1;
      addr = `INIT_ADDR;
      data = 32'(`INIT_DATA);
    end else if (running) begin
      we   = cpu_req.we;
      addr = int'(cpu_req.addr);
      data = cpu_req.data;
    end else begin // Port A parked on word 0 while idle
      we   = 1'b0;
      addr = 0;
      data = '0;
      if (cpu_req.we) begin
        idle_hit[cpu_req.addr]  = 1'b1;
        idle_data[cpu_req.addr] = cpu_req.data;
      end
    end
    // Read data now belongs to last cycle's address
    if (pend.known && cpu_read_data !== pend.data) begin
      read_errors++;
      report($sformatf("[ERROR] cpu_read_data: expected 0x%08h got 0x%08h",
                       pend.data, cpu_read_data));
    end else if (!pend.known && pend.idle_hit && cpu_read_data === pend.idle_data) begin
      read_errors++;
      report("A write made while the controller was idle reached the frame RAM");
    end
    pend.known     = known[addr];
    pend.idle_hit  = idle_hit[addr];
    pend.data      = model[addr]; // Read first
    pend.idle_data = idle_data[addr];
    if (we) begin
      model[addr]   = data;
      known[addr]   = 1'b1;
      last_wr[addr] = cyc;
    end
    init_now = !running && !btn; // Start edge ends this cycle
    if (init_now) running = 1'b1;
  endtask

  task automatic check_video();
    int          h;
    int          tile;
    logic        exp_hs;
    logic        exp_vs;
    logic        exp_act;
    logic        do_color;
    logic [23:0] exp_color;
    if (locked) begin
      hc = (hc == 2 * H_TOTAL - 1) ? 0 : hc + 1;
      if (hc == 0) vc = (vc == V_TOTAL - 1) ? 0 : vc + 1;
    end else if (prev_vsync && !video.vsync) begin
      locked = 1'b1; // Falling vsync is pixel 0 of the first sync line
      hc     = 0;
      vc     = VS_FIRST;
    end else if (cyc == LOCK_LIMIT) begin
      sync_errors++;
      report("No falling vsync within the first frame, raster checks never started");
    end
    prev_vsync = video.vsync;
    if (locked) begin
      h       = hc / 2;
      exp_hs  = !(h >= HS_FIRST && h < HS_FIRST + `H_SYNC);
      exp_vs  = !(vc >= VS_FIRST && vc < VS_FIRST + `V_SYNC);
      exp_act = (h < `H_ACTIVE) && (vc < `V_ACTIVE);
      if (video.hsync !== exp_hs || video.vsync !== exp_vs) begin
        sync_errors++;
        report($sformatf("[ERROR] video.hsync/vsync at x=%0d y=%0d: expected 0x%0h got 0x%0h",
                         h, vc, {exp_hs, exp_vs}, {video.hsync, video.vsync}));
      end
      if (video.sync_b !== (exp_hs & exp_vs)) begin // Composite sync
        sync_errors++;
        report($sformatf("[ERROR] video.sync_b at x=%0d y=%0d: expected 0x%0h got 0x%0h",
                         h, vc, exp_hs & exp_vs, video.sync_b));
      end
      if (video.blank_b !== exp_act) begin
        sync_errors++;
        report($sformatf("[ERROR] video.blank_b at x=%0d y=%0d: expected 0x%0h got 0x%0h",
                         h, vc, exp_act, video.blank_b));
      end
      exp_color = 24'h0;
      do_color  = 1'b1;
      if (exp_act) begin
        tile      = (vc / `TILE_H) * `TILE_COLS + h / `TILE_W;
        exp_color = model[tile][23:0];
        do_color  = known[tile] && (cyc - last_wr[tile] > 2); // Shown two clocks after the read
      end
      if (do_color && video.color !== exp_color) begin
        color_errors++;
        report($sformatf("[ERROR] video.color at x=%0d y=%0d: expected 0x%06h got 0x%06h",
                         h, vc, exp_color, video.color));
      end
    end
  endtask

  always @(negedge clk) begin
    if (reset) begin
      running    = 1'b0;
      init_now   = 1'b0;
      pend       = '0;
      locked     = 1'b0;
      prev_vsync = 1'b1;
      cyc        = 0;
    end else begin
      cyc = cyc + 1;
      check_bus();
      check_video();
    end
  end

endmodule

`default_nettype wire

/* test/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sys_cfg.svh"

// Plays the processor and the button
// Comparing happens in tb_checker
module tb_top;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_WRITES = 40;
  localparam int TRAFFIC_OPS = 3000;
  localparam int WORDS = 1 << `RAM_ADDR_W;
  localparam int LINE_CLKS = 2 * (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK);
  localparam int FRAME_CLKS = LINE_CLKS * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
  localparam longint LIMIT_CLKS = 4 * FRAME_CLKS + 2 * (IDLE_WRITES + TRAFFIC_OPS + WORDS);

  logic                  clk;
  logic                  reset;
  logic                  btn;
  bus_pkg::mem_req_t     cpu_req;
  logic [31:0]           cpu_read_data;
  logic                  cpu_reset;
  video_pkg::video_out_t video;
  int                    ctrl_errors;
  int                    read_errors;
  int                    sync_errors;
  int                    color_errors;
  int                    start_errors;
  logic [`RAM_ADDR_W-1:0] idle_addrs [$]; // Targets of the ignored writes

  vga_system u_dut (
    .clk           (clk),
    .reset         (reset),
    .btn           (btn),
    .cpu_req       (cpu_req),
    .cpu_read_data (cpu_read_data),
    .cpu_reset     (cpu_reset),
    .video         (video)
  );

  tb_checker u_checker (
    .clk           (clk),
    .reset         (reset),
    .btn           (btn),
    .cpu_req       (cpu_req),
    .cpu_read_data (cpu_read_data),
    .cpu_reset     (cpu_reset),
    .video         (video),
    .ctrl_errors   (ctrl_errors),
    .read_errors   (read_errors),
    .sync_errors   (sync_errors),
    .color_errors  (color_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [`RAM_ADDR_W-1:0] random_addr();
    return `RAM_ADDR_W'($urandom);
  endfunction

  task automatic drive_write(input logic [`RAM_ADDR_W-1:0] addr, input logic [31:0] data);
    next_cycle();
    cpu_req.we   = 1'b1;
    cpu_req.addr = addr;
    cpu_req.data = data;
  endtask

  task automatic drive_read(input logic [`RAM_ADDR_W-1:0] addr);
    next_cycle();
    cpu_req.we   = 1'b0;
    cpu_req.addr = addr;
    cpu_req.data = $urandom; // Ignored without the strobe
  endtask

  // Button held low until the processor is released
  task automatic press_button();
    int waited;
    next_cycle();
    cpu_req = '0;
    btn     = 1'b0;
    waited  = 0;
    while (cpu_reset && waited < 8) begin
      next_cycle();
      waited++;
    end
    if (cpu_reset) begin
      start_errors++;
      $display("Processor was not released within 8 clocks of the button press");
    end
    btn = 1'b1;
  endtask

  initial begin
    int total;
    reset        = 1'b1;
    btn          = 1'b1; // Not pressed
    cpu_req      = '0;
    start_errors = 0;
    void'($urandom(32'h99495add));
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    // Writes while idle must be dropped
    for (int i = 0; i < IDLE_WRITES; i++) begin
      idle_addrs.push_back(random_addr());
      drive_write(idle_addrs[i], $urandom);
    end
    press_button();
    drive_read(`RAM_ADDR_W'(`INIT_ADDR)); // Seed word
    foreach (idle_addrs[k]) drive_read(idle_addrs[k]);
    for (int n = 0; n < TRAFFIC_OPS; n++) begin
      if ($urandom_range(1, 0) == 1) drive_write(random_addr(), $urandom);
      else drive_read(random_addr());
    end
    // One tile per line time
    // About a frame for the whole grid
    for (int t = 0; t < WORDS; t++) begin
      drive_write(`RAM_ADDR_W'(t), $urandom);
      repeat (LINE_CLKS - 1) drive_read(random_addr());
    end
    repeat (2 * FRAME_CLKS) drive_read(random_addr()); // Observe only
    repeat (4) next_cycle();
    total = ctrl_errors + read_errors + sync_errors + color_errors + start_errors;
    $display("Errors: control %0d, read %0d, sync %0d, color %0d, start %0d, total %0d",
             ctrl_errors, read_errors, sync_errors, color_errors, start_errors, total);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Four frames plus the traffic
  initial begin
    #(LIMIT_CLKS * CLK_PERIOD);
    $display("Watchdog expired after %0d clocks, run did not complete", LIMIT_CLKS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/vga_system_sva.sv */
`timescale 1ns/1ns
`default_nettype none

// Properties on the top level, attached to vga_system by bind
module vga_system_sva (
  input logic                  clk,
  input logic                  reset,
  input logic                  init_pulse, // Seed write select inside run control
  input logic                  cpu_reset,
  input video_pkg::video_out_t video
);

  // Seed write owns port A for a single clock
  init_single: assert property (@(posedge clk) disable iff (reset)
    init_pulse |=> !init_pulse)
    else $error("Initialization pulse lasted more than one clock");

  // Released once, released for good
  release_sticky: assert property (@(posedge clk) disable iff (reset)
    !cpu_reset |=> !cpu_reset)
    else $error("cpu_reset rose again after the processor was released");

  // No picture while either sync is active
  blank_in_sync: assert property (@(posedge clk) disable iff (reset)
    (!video.hsync || !video.vsync) |-> !video.blank_b)
    else $error("blank_b high while a sync pulse is active");

endmodule

bind vga_system vga_system_sva u_sva (
  .clk        (clk),
  .reset      (reset),
  .init_pulse (u_run_control.init_pulse),
  .cpu_reset  (cpu_reset),
  .video      (video)
);

`default_nettype wire
